// File: Bender.yml
package:
  name: slurm16_memory_subsystem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_bus_pkg.sv
      - hdl/mem_channel_pkg.sv
      - hdl/mem_req_if.sv
      - hdl/instr_fetch_port.sv
      - hdl/data_access_port.sv
      - hdl/memory_arbiter.sv
      - hdl/banked_ram.sv
      - hdl/cpu_memory_subsystem.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/memory_checker.sv
      - tests/tb_memory_subsystem.sv

// File: build.f
+incdir+hdl
hdl/mem_bus_pkg.sv
hdl/mem_channel_pkg.sv
hdl/mem_req_if.sv
hdl/instr_fetch_port.sv
hdl/data_access_port.sv
hdl/memory_arbiter.sv
hdl/banked_ram.sv
hdl/cpu_memory_subsystem.sv
tests/memory_checker.sv
tests/tb_memory_subsystem.sv

// File: hdl/banked_ram.sv
`timescale 1ns/10ps

`include "slurm16_defs.svh"

module banked_ram
	import mem_bus_pkg::*;
(
	input  logic                      CLK,
	input  logic                      RSTb,
	input  logic [`SLURM_ADDR_BITS:0] mem_addr,
	input  logic [`SLURM_BITS-1:0]    wdata,
	input  logic                      mem_wr,
	input  logic                      valid,
	output logic                      rdy,
	output logic [`SLURM_BITS-1:0]    rdata
);

	localparam int BANK_WORDS = 2 ** `SLURM_BANK_BIT;
	localparam int CNT_BITS   = $clog2(`SLURM_GRANT_DELAY + 1);

	logic [`SLURM_BITS-1:0] bank0_mem [BANK_WORDS];
	logic [`SLURM_BITS-1:0] bank1_mem [BANK_WORDS];

	mem_addr_u              addr_in;
	// Address and data one cycle back, used by the write
	mem_addr_u              addr_q;
	logic [`SLURM_BITS-1:0] wdata_q;
	logic [CNT_BITS-1:0]    grant_cnt;

	assign addr_in.word = mem_addr[`SLURM_ADDR_BITS-1:0];

	// Grant counter, restarts whenever valid drops
	always_ff @(posedge CLK) begin
		if (!RSTb)
			grant_cnt <= '0;
		else if (!valid)
			grant_cnt <= '0;
		else if (grant_cnt != `SLURM_GRANT_DELAY)
			grant_cnt <= grant_cnt + 1'b1;
	end

	assign rdy = valid && (grant_cnt == `SLURM_GRANT_DELAY);

	// Write lands in the bank named by the stored address
	always_ff @(posedge CLK) begin
		if (mem_wr) begin
			if (addr_q.split.bank)
				bank1_mem[addr_q.split.offset] <= wdata_q;
			else
				bank0_mem[addr_q.split.offset] <= wdata_q;
		end
	end

	// Registered read
	always_ff @(posedge CLK) begin
		addr_q  <= addr_in;
		wdata_q <= wdata;
		// Same-address write this edge, hand the new word over
		if (mem_wr && (addr_q == addr_in))
			rdata <= wdata_q;
		else if (addr_in.split.bank)
			rdata <= bank1_mem[addr_in.split.offset];
		else
			rdata <= bank0_mem[addr_in.split.offset];
	end

	a_wr_needs_rdy: assert property (@(posedge CLK) disable iff (!RSTb) mem_wr |-> rdy);

	a_addr_top_low: assert property (@(posedge CLK) disable iff (!RSTb)
		valid |-> !mem_addr[`SLURM_ADDR_BITS]);

endmodule

// File: hdl/cpu_memory_subsystem.sv
`timescale 1ns/10ps

`include "slurm16_defs.svh"

module cpu_memory_subsystem (
	input  logic                        CLK,
	input  logic                        RSTb,
	// Instruction channel
	input  logic [`SLURM_ADDR_BITS-1:0] i_addr,
	input  logic                        i_req,
	output logic [`SLURM_BITS-1:0]      i_data,
	output logic [`SLURM_ADDR_BITS-1:0] i_addr_out,
	output logic                        i_success,
	// Data channel
	input  logic [`SLURM_ADDR_BITS-1:0] d_addr,
	input  logic [`SLURM_BITS-1:0]      d_wdata,
	input  logic                        d_rd,
	input  logic                        d_wr,
	output logic [`SLURM_BITS-1:0]      d_rdata,
	output logic                        d_success,
	// High while the arbiter moves between banks
	output logic                        bank_sw
);

	logic [`SLURM_ADDR_BITS:0] mem_addr;
	logic [`SLURM_BITS-1:0]    ram_wdata;
	logic [`SLURM_BITS-1:0]    ram_rdata;
	logic                      mem_wr;
	logic                      valid;
	logic                      rdy;

	mem_req_if ich_bus ();
	mem_req_if dch_bus ();

	instr_fetch_port u_ifetch (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.i_addr     (i_addr),
		.i_req      (i_req),
		.i_data     (i_data),
		.i_addr_out (i_addr_out),
		.i_success  (i_success),
		.bus        (ich_bus.port)
	);

	data_access_port u_daccess (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.d_addr    (d_addr),
		.d_wdata   (d_wdata),
		.d_rd      (d_rd),
		.d_wr      (d_wr),
		.d_rdata   (d_rdata),
		.d_success (d_success),
		.bus       (dch_bus.port)
	);

	memory_arbiter u_arbiter (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.ich      (ich_bus.arbiter),
		.dch      (dch_bus.arbiter),
		.bank_sw  (bank_sw),
		.mem_addr (mem_addr),
		.wdata    (ram_wdata),
		.mem_wr   (mem_wr),
		.valid    (valid),
		.rdy      (rdy),
		.rdata    (ram_rdata)
	);

	banked_ram u_ram (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.mem_addr (mem_addr),
		.wdata    (ram_wdata),
		.mem_wr   (mem_wr),
		.valid    (valid),
		.rdy      (rdy),
		.rdata    (ram_rdata)
	);

endmodule

// File: hdl/data_access_port.sv
`timescale 1ns/10ps

`include "slurm16_defs.svh"

module data_access_port
	import mem_bus_pkg::*;
(
	input  logic                   CLK,
	input  logic                   RSTb,
	input  mem_addr_u              d_addr,
	input  logic [`SLURM_BITS-1:0] d_wdata,
	input  logic                   d_rd,
	input  logic                   d_wr,
	output logic [`SLURM_BITS-1:0] d_rdata,
	output logic                   d_success,
	mem_req_if.port                bus
);

	logic req_live;
	logic own_success;
	logic access_done;

	// Arbiter success aimed at this channel
	assign own_success = bus.success && bus.was_requested;

	// Request is off while the success pulse is out
	// so a CPU request still held is not taken twice
	assign req_live = (d_rd || d_wr) && !d_success;

	// Also drop it in the success cycle itself
	// Stops one more capture from landing after the pulse
	assign bus.rd = d_rd && !d_success && !own_success;
	assign bus.wr = d_wr && !d_success && !own_success;

	// Address and data come straight from the CPU, held by it
	assign bus.addr  = d_addr;
	assign bus.wdata = d_wdata;

	// Duplicate slots that finish during the pulse are dropped here
	assign access_done = req_live && own_success;

	always_ff @(posedge CLK) begin
		if (!RSTb)
			d_success <= 1'b0;
		else
			d_success <= access_done;
	end

	// Read word only, writes leave the last value
	always_ff @(posedge CLK) begin
		if (access_done && d_rd)
			d_rdata <= bus.rdata;
	end

endmodule

// File: hdl/instr_fetch_port.sv
`timescale 1ns/10ps

`include "slurm16_defs.svh"

module instr_fetch_port
	import mem_bus_pkg::*;
(
	input  logic                   CLK,
	input  logic                   RSTb,
	input  mem_addr_u              i_addr,
	input  logic                   i_req,
	output logic [`SLURM_BITS-1:0] i_data,
	output mem_addr_u              i_addr_out,
	output logic                   i_success,
	mem_req_if.port                bus
);

	logic addr_match;
	logic fetch_done;

	// Fetch goes straight through, fetches never write
	assign bus.addr  = i_addr;
	assign bus.rd    = i_req;
	assign bus.wr    = 1'b0;
	assign bus.wdata = '0;

	// Returned slot must be the address still being asked for
	// Older duplicates in the pipe fail this and the fetch retries
	assign addr_match = (bus.addr_back.word == i_addr.word);
	assign fetch_done = i_req && bus.success && bus.was_requested && addr_match;

	always_ff @(posedge CLK) begin
		if (!RSTb)
			i_success <= 1'b0;
		else
			i_success <= fetch_done;
	end

	// Word and address captured together
	always_ff @(posedge CLK) begin
		if (fetch_done) begin
			i_data     <= bus.rdata;
			i_addr_out <= bus.addr_back;
		end
	end

endmodule

// File: hdl/mem_bus_pkg.sv
`include "slurm16_defs.svh"

package mem_bus_pkg;

	// Bank/offset split of a word address
	typedef struct packed {
		logic                       bank;
		logic [`SLURM_BANK_BIT-1:0] offset;
	} mem_bank_addr_t;

	// One address, two readings
	// Flat word for compare and pass-back, split for bank array select
	typedef union packed {
		logic [`SLURM_ADDR_BITS-1:0] word;
		mem_bank_addr_t              split;
	} mem_addr_u;

	// Arbiter FSM
	typedef enum logic [1:0] {
		st_idle         = 2'd0,
		st_request_bank = 2'd1,
		st_execute      = 2'd2,
		st_bank_switch  = 2'd3
	} arb_state_e;

endpackage

// File: hdl/mem_channel_pkg.sv
package mem_channel_pkg;

	// Who owns a pipeline slot
	typedef enum logic {
		src_data  = 1'b0,
		src_instr = 1'b1
	} req_src_e;

	// Read is 1 so the field reads as rd-not-wr
	typedef enum logic {
		op_write = 1'b0,
		op_read  = 1'b1
	} mem_op_e;

	// Per-slot flags carried down the arbiter pipeline
	typedef struct packed {
		logic     requested;
		req_src_e requestor;
		mem_op_e  op;
	} pipe_flags_t;

endpackage

// File: hdl/mem_req_if.sv
`timescale 1ns/10ps

`include "slurm16_defs.svh"

interface mem_req_if
	import mem_bus_pkg::*;
();

	// Request side, held until success
	mem_addr_u               addr;
	logic [`SLURM_BITS-1:0] wdata;
	logic                    rd;
	logic                    wr;

	// Response side, valid while success is high
	logic                    success;
	logic [`SLURM_BITS-1:0] rdata;
	mem_addr_u               addr_back;
	// Stage-2 slot belongs to this channel
	logic                    was_requested;

	modport port (
		output addr, wdata, rd, wr,
		input  success, rdata, addr_back, was_requested
	);

	modport arbiter (
		input  addr, wdata, rd, wr,
		output success, rdata, addr_back, was_requested
	);

endinterface

// File: hdl/memory_arbiter.sv
`timescale 1ns/10ps

`include "slurm16_defs.svh"

module memory_arbiter
	import mem_bus_pkg::*;
	import mem_channel_pkg::*;
(
	input  logic                        CLK,
	input  logic                        RSTb,
	mem_req_if.arbiter                  ich,
	mem_req_if.arbiter                  dch,
	output logic                        bank_sw,
	output logic [`SLURM_ADDR_BITS:0]   mem_addr,
	output logic [`SLURM_BITS-1:0]      wdata,
	output logic                        mem_wr,
	output logic                        valid,
	input  logic                        rdy,
	input  logic [`SLURM_BITS-1:0]      rdata
);

	// Stage 1 is on the RAM pins, stage 2 has its result,
	// stage 3 only remembers the bank last served
	mem_addr_u              addr_s1, addr_s1_next;
	mem_addr_u              addr_s2;
	mem_addr_u              addr_s3;
	logic [`SLURM_BITS-1:0] data_s1, data_s1_next;
	logic [`SLURM_BITS-1:0] data_s2;
	pipe_flags_t            flags_s1, flags_s1_next;
	pipe_flags_t            flags_s2;

	arb_state_e state, next_state;

	logic d_pending;
	logic i_pending;
	logic bank_switch_required;
	logic slot_ok;
	logic d_owns;
	logic i_owns;

	// Flags for a freshly captured request
	function automatic pipe_flags_t new_flags(input req_src_e src, input logic is_read);
		pipe_flags_t f;
		f.requested = 1'b1;
		f.requestor = src;
		if (is_read)
			f.op = op_read;
		else
			f.op = op_write;
		return f;
	endfunction

	assign d_pending = dch.rd || dch.wr;
	assign i_pending = ich.rd || ich.wr;

	// Bank moved between the last two slots
	assign bank_switch_required =
		addr_s2.word[`SLURM_BANK_BIT] != addr_s3.word[`SLURM_BANK_BIT];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state    <= st_idle;
			addr_s1  <= '0;
			flags_s1 <= '0;
			addr_s2  <= '0;
			flags_s2 <= '0;
			addr_s3  <= '0;
		end else begin
			state    <= next_state;
			addr_s1  <= addr_s1_next;
			flags_s1 <= flags_s1_next;
			// Later stages advance every cycle
			addr_s2  <= addr_s1;
			flags_s2 <= flags_s1;
			addr_s3  <= addr_s2;
		end
	end

	always_ff @(posedge CLK) begin
		data_s1 <= data_s1_next;
		data_s2 <= data_s1;
	end

	always_comb begin
		next_state    = state;
		addr_s1_next  = addr_s1;
		data_s1_next  = data_s1;
		flags_s1_next = flags_s1;
		case (state)
			st_idle: begin
				if (d_pending || i_pending)
					next_state = st_request_bank;
			end
			st_request_bank: begin
				// Stage 1 holds the new-bank address while waiting
				if (rdy)
					next_state = st_execute;
			end
			st_execute: begin
				if (bank_switch_required) begin
					// Park stage 2 in stage 1 as a read only
					// A write stays unclaimed until the retry comes back
					next_state              = st_bank_switch;
					addr_s1_next            = addr_s2;
					data_s1_next            = data_s2;
					flags_s1_next.op        = op_read;
					flags_s1_next.requestor = flags_s2.requestor;
					flags_s1_next.requested = flags_s2.requested && (flags_s2.op == op_read);
				end else if (d_pending) begin
					// Data first
					addr_s1_next  = dch.addr;
					data_s1_next  = dch.wdata;
					flags_s1_next = new_flags(src_data, dch.rd);
				end else if (i_pending) begin
					addr_s1_next  = ich.addr;
					data_s1_next  = ich.wdata;
					flags_s1_next = new_flags(src_instr, ich.rd);
				end else begin
					// Nothing to do, keep the address so the bank is remembered
					data_s1_next  = '0;
					flags_s1_next = '0;
					next_state    = st_idle;
				end
			end
			st_bank_switch: begin
				// One cycle with valid low
				next_state = st_request_bank;
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	// Stage 2 slot is good only with the bank unchanged
	assign slot_ok = (state == st_execute) && !bank_switch_required;

	assign d_owns = flags_s2.requested && (flags_s2.requestor == src_data);
	assign i_owns = flags_s2.requested && (flags_s2.requestor == src_instr);

	assign dch.was_requested = d_owns;
	assign ich.was_requested = i_owns;
	assign dch.success       = d_owns && slot_ok;
	assign ich.success       = i_owns && slot_ok;

	// Same returned word and slot address on both channels
	assign dch.rdata     = rdata;
	assign ich.rdata     = rdata;
	assign dch.addr_back = addr_s2;
	assign ich.addr_back = addr_s2;

	// RAM side, 16-bit address with the top bit low
	assign mem_addr = {1'b0, addr_s1.word};
	assign wdata    = data_s1;
	// Write commits on the RAM's stage-2 copy of address and data
	assign mem_wr   = d_owns && (flags_s2.op == op_write) && slot_ok;

	assign bank_sw = (state == st_bank_switch) || (state == st_request_bank);
	assign valid   = (state == st_request_bank) || (state == st_execute);

	a_wr_granted: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_wr |-> valid && rdy);

endmodule

// File: hdl/slurm16_defs.svh
`ifndef SLURM16_DEFS_SVH
`define SLURM16_DEFS_SVH

// Word width of the CPU and of each RAM location
`define SLURM_BITS 16

// CPU word address width
`define SLURM_ADDR_BITS 15

// Bank select bit in the word address
// Everything below it is the offset inside a bank
`define SLURM_BANK_BIT 14

// Cycles from valid rising to rdy in the RAM
// Bank requests pay this on every switch
`define SLURM_GRANT_DELAY 2

`endif

// File: tests/memory_checker.sv
`timescale 1ns/10ps

`include "slurm16_defs.svh"

module memory_checker (
	input  logic                        CLK,
	input  logic                        RSTb,
	// CPU requests, to spot the first one after reset
	input  logic                        i_req,
	input  logic                        d_rd,
	input  logic                        d_wr,
	// DUT responses
	input  logic                        i_success,
	input  logic [`SLURM_BITS-1:0]      i_data,
	input  logic [`SLURM_ADDR_BITS-1:0] i_addr_out,
	input  logic                        d_success,
	input  logic [`SLURM_BITS-1:0]      d_rdata,
	input  logic                        bank_sw,
	// Expectations for the access in flight
	input  logic                        op_start,
	input  logic                        exp_d,
	input  logic                        exp_i,
	input  logic                        chk_d_read,
	input  logic                        chk_order,
	input  logic                        chk_sw,
	input  logic [`SLURM_BITS-1:0]      exp_d_data,
	input  logic [`SLURM_BITS-1:0]      exp_i_data,
	input  logic [`SLURM_ADDR_BITS-1:0] exp_i_addr,
	output int                          check_count,
	output int                          error_count
);

	// Any request since reset
	logic seen_req;
	// Per-access bookkeeping
	logic d_seen;
	logic i_seen;
	// Separate bank_sw pulses in this access
	int   sw_rises;
	logic sw_prev;

	initial begin
		check_count = 0;
		error_count = 0;
		seen_req    = 1'b0;
		d_seen      = 1'b0;
		i_seen      = 1'b0;
		sw_rises    = 0;
		sw_prev     = 1'b0;
	end

	// Sampled on the rising edge, inputs moved 2 ns after it
	always @(posedge CLK) begin : watch
		logic d_before;
		if (!RSTb) begin
			seen_req = 1'b0;
			d_seen   = 1'b0;
			i_seen   = 1'b0;
			sw_rises = 0;
			sw_prev  = 1'b0;
		end else begin
			// Quiet outputs until the first request
			if (!seen_req && (i_success || d_success || bank_sw)) begin
				error_count++;
				$display("Output active before any request: i_success=%b d_success=%b bank_sw=%b",
					i_success, d_success, bank_sw);
			end
			if (i_req || d_rd || d_wr)
				seen_req = 1'b1;
			// New access starts clean
			if (op_start) begin
				d_seen   = 1'b0;
				i_seen   = 1'b0;
				sw_rises = 0;
			end
			// Grant from idle gives one bank_sw pulse
			// A bank change adds a second one
			if (bank_sw && !sw_prev)
				sw_rises++;
			sw_prev = bank_sw;
			// Order is judged on earlier cycles only
			d_before = d_seen;
			if (d_success) begin
				check_count++;
				if (!exp_d) begin
					error_count++;
					$display("d_success pulsed with no data access in flight");
				end else if (d_seen) begin
					error_count++;
					$display("d_success pulsed twice for one data access");
				end
				if (exp_d && !d_seen && chk_sw && sw_rises < 2) begin
					error_count++;
					$display("No bank switch seen before the data success of a cross-bank access");
				end
				if (exp_d && chk_d_read && d_rdata !== exp_d_data) begin
					error_count++;
					$display("FAILED d_rdata: got 0x%h, expected 0x%h", d_rdata, exp_d_data);
				end
				d_seen = 1'b1;
			end
			if (i_success) begin
				check_count++;
				if (!exp_i) begin
					error_count++;
					$display("i_success pulsed with no fetch in flight");
				end else if (i_seen) begin
					error_count++;
					$display("i_success pulsed twice for one fetch");
				end
				// Data has priority when both ask together
				if (exp_i && chk_order && !d_before) begin
					error_count++;
					$display("i_success arrived before d_success on a combined access");
				end
				if (exp_i && !i_seen && !chk_order && chk_sw && sw_rises < 2) begin
					error_count++;
					$display("No bank switch seen before the fetch success of a cross-bank access");
				end
				if (exp_i && i_data !== exp_i_data) begin
					error_count++;
					$display("FAILED i_data: got 0x%h, expected 0x%h", i_data, exp_i_data);
				end
				if (exp_i && i_addr_out !== exp_i_addr) begin
					error_count++;
					$display("FAILED i_addr_out: got 0x%h, expected 0x%h", i_addr_out, exp_i_addr);
				end
				i_seen = 1'b1;
			end
		end
	end

endmodule

// File: tests/memory_stimulus.txt
# op addr wdata expected, all hex; W write, R read, I fetch, B data read and fetch together
# Address bit 14 selects the bank; wdata is used by W only, expected by R, I and B
W 0010 1234 0000
R 0010 0000 1234
W 4010 abcd 0000
R 4010 0000 abcd
R 0010 0000 1234
I 0010 0000 1234
I 4010 0000 abcd
W 0011 5a5a 0000
I 0011 0000 5a5a
B 0011 0000 5a5a
B 4010 0000 abcd
W 0030 1111 0000
W 4030 2222 0000
R 0030 0000 1111
R 4030 0000 2222
W 0030 3333 0000
R 4030 0000 2222
R 0030 0000 3333
W 7fff beef 0000
W 3fff cafe 0000
R 7fff 0000 beef
I 3fff 0000 cafe
B 0010 0000 1234
R 4010 0000 abcd

// File: tests/tb_memory_subsystem.sv
`timescale 1ns/10ps

`include "slurm16_defs.svh"

module tb_memory_subsystem;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int DRIVE_DELAY    = 2;

	logic                        CLK;
	logic                        RSTb;
	logic [`SLURM_ADDR_BITS-1:0] i_addr;
	logic                        i_req;
	logic [`SLURM_BITS-1:0]      i_data;
	logic [`SLURM_ADDR_BITS-1:0] i_addr_out;
	logic                        i_success;
	logic [`SLURM_ADDR_BITS-1:0] d_addr;
	logic [`SLURM_BITS-1:0]      d_wdata;
	logic                        d_rd;
	logic                        d_wr;
	logic [`SLURM_BITS-1:0]      d_rdata;
	logic                        d_success;
	logic                        bank_sw;

	// Expectations handed to the checker
	logic                        op_start;
	logic                        exp_d;
	logic                        exp_i;
	logic                        chk_d_read;
	logic                        chk_order;
	logic                        chk_sw;
	logic [`SLURM_BITS-1:0]      exp_d_data;
	logic [`SLURM_BITS-1:0]      exp_i_data;
	logic [`SLURM_ADDR_BITS-1:0] exp_i_addr;

	int   check_count;
	int   error_count;
	int   timeout_count;
	int   file_errors;
	int   op_count;
	logic aborted;
	logic have_prev;
	logic prev_bank;

	cpu_memory_subsystem uut (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.i_addr     (i_addr),
		.i_req      (i_req),
		.i_data     (i_data),
		.i_addr_out (i_addr_out),
		.i_success  (i_success),
		.d_addr     (d_addr),
		.d_wdata    (d_wdata),
		.d_rd       (d_rd),
		.d_wr       (d_wr),
		.d_rdata    (d_rdata),
		.d_success  (d_success),
		.bank_sw    (bank_sw)
	);

	memory_checker u_check (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.i_req       (i_req),
		.d_rd        (d_rd),
		.d_wr        (d_wr),
		.i_success   (i_success),
		.i_data      (i_data),
		.i_addr_out  (i_addr_out),
		.d_success   (d_success),
		.d_rdata     (d_rdata),
		.bank_sw     (bank_sw),
		.op_start    (op_start),
		.exp_d       (exp_d),
		.exp_i       (exp_i),
		.chk_d_read  (chk_d_read),
		.chk_order   (chk_order),
		.chk_sw      (chk_sw),
		.exp_d_data  (exp_d_data),
		.exp_i_data  (exp_i_data),
		.exp_i_addr  (exp_i_addr),
		.check_count (check_count),
		.error_count (error_count)
	);

	// 40 ns clock
	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// Poll once per cycle until every wanted success is in
	task automatic wait_for_success(input logic want_d, input logic want_i,
			input logic [`SLURM_ADDR_BITS-1:0] addr);
		int   cycles;
		logic d_done;
		logic i_done;
		cycles = 0;
		d_done = !want_d;
		i_done = !want_i;
		while (!(d_done && i_done) && cycles < TIMEOUT_CYCLES) begin
			@(posedge CLK);
			#DRIVE_DELAY;
			cycles++;
			// Start marker lasts one cycle
			op_start = 1'b0;
			if (!d_done && d_success) begin
				d_done = 1'b1;
				d_rd   = 1'b0;
				d_wr   = 1'b0;
			end
			if (!i_done && i_success) begin
				i_done = 1'b1;
				i_req  = 1'b0;
			end
		end
		if (!(d_done && i_done)) begin
			timeout_count++;
			aborted = 1'b1;
			d_rd    = 1'b0;
			d_wr    = 1'b0;
			i_req   = 1'b0;
			if (!d_done)
				$display("Timeout: no d_success within %0d cycles for address %h",
					TIMEOUT_CYCLES, addr);
			if (!i_done)
				$display("Timeout: no i_success within %0d cycles for address %h",
					TIMEOUT_CYCLES, addr);
		end
	endtask

	// One line of the stimulus file, W write, R read, I fetch, B read and fetch
	task automatic run_access(input logic [7:0] op_ch,
			input logic [`SLURM_ADDR_BITS-1:0] addr,
			input logic [`SLURM_BITS-1:0] wdata,
			input logic [`SLURM_BITS-1:0] expect_word);
		logic bank;
		bank       = addr[`SLURM_BANK_BIT];
		exp_d      = 1'b0;
		exp_i      = 1'b0;
		chk_d_read = 1'b0;
		chk_order  = 1'b0;
		exp_d_data = expect_word;
		exp_i_data = expect_word;
		exp_i_addr = addr;
		// Moving to the other bank must show bank_sw first
		chk_sw     = have_prev && (bank != prev_bank);
		case (op_ch)
			"W": begin
				d_addr  = addr;
				d_wdata = wdata;
				d_wr    = 1'b1;
				exp_d   = 1'b1;
			end
			"R": begin
				d_addr     = addr;
				d_rd       = 1'b1;
				exp_d      = 1'b1;
				chk_d_read = 1'b1;
			end
			"I": begin
				i_addr = addr;
				i_req  = 1'b1;
				exp_i  = 1'b1;
			end
			"B": begin
				d_addr     = addr;
				d_rd       = 1'b1;
				i_addr     = addr;
				i_req      = 1'b1;
				exp_d      = 1'b1;
				exp_i      = 1'b1;
				chk_d_read = 1'b1;
				chk_order  = 1'b1;
			end
			default: begin
				file_errors++;
				$display("Unknown operation %s in the stimulus file", op_ch);
			end
		endcase
		if (exp_d || exp_i) begin
			op_count++;
			op_start = 1'b1;
			wait_for_success(exp_d, exp_i, addr);
			have_prev = 1'b1;
			prev_bank = bank;
		end
	endtask

	initial begin : stimulus
		int                          fd;
		int                          n;
		int                          gap;
		int                          seed_ret;
		string                       line;
		logic [7:0]                  op_ch;
		logic [`SLURM_ADDR_BITS-1:0] addr;
		logic [`SLURM_BITS-1:0]      wdata;
		logic [`SLURM_BITS-1:0]      expect_word;
		seed_ret      = $urandom(47668);
		RSTb          = 1'b0;
		i_addr        = '0;
		i_req         = 1'b0;
		d_addr        = '0;
		d_wdata       = '0;
		d_rd          = 1'b0;
		d_wr          = 1'b0;
		op_start      = 1'b0;
		exp_d         = 1'b0;
		exp_i         = 1'b0;
		chk_d_read    = 1'b0;
		chk_order     = 1'b0;
		chk_sw        = 1'b0;
		exp_d_data    = '0;
		exp_i_data    = '0;
		exp_i_addr    = '0;
		timeout_count = 0;
		file_errors   = 0;
		op_count      = 0;
		aborted       = 1'b0;
		have_prev     = 1'b0;
		prev_bank     = 1'b0;
		repeat (4) @(posedge CLK);
		#DRIVE_DELAY;
		RSTb = 1'b1;
		// A few quiet cycles so the idle outputs get watched
		repeat (3) @(posedge CLK);
		#DRIVE_DELAY;
		fd = $fopen("tests/memory_stimulus.txt", "r");
		if (fd == 0) begin
			file_errors++;
			$display("Could not open the stimulus file tests/memory_stimulus.txt");
		end else begin
			while (!aborted && !$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0) begin
					// Comment and blank lines give fewer than four fields
					n = $sscanf(line, "%s %h %h %h", op_ch, addr, wdata, expect_word);
					if (n == 4 && op_ch != "#") begin
						run_access(op_ch, addr, wdata, expect_word);
						// Random idle gap, at least one cycle so the checker sees the result
						gap = 1 + ($urandom % 4);
						repeat (gap) @(posedge CLK);
						#DRIVE_DELAY;
					end
				end
			end
			$fclose(fd);
		end
		repeat (2) @(posedge CLK);
		#DRIVE_DELAY;
		$display("Summary: %0d accesses, %0d checks, %0d errors, %0d timeouts, %0d file errors",
			op_count, check_count, error_count, timeout_count, file_errors);
		if (error_count == 0 && timeout_count == 0 && file_errors == 0 && op_count > 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
